//--- sources.f
+incdir+common
common/bus_pkg.sv
common/mem_req_if.sv
src/req_arbiter.sv
src/addr_router.sv
src/clint_timer.sv
axi_master/axi_lane_adapter.sv
src/bus_unit_top.sv
tb/axi_mem_model.sv
tb/tb_bus_unit.sv

//--- Bender.yml
package:
  name: bus_unit

sources:
  - include_dirs:
      - common
    files:
      - common/bus_pkg.sv
      - common/mem_req_if.sv
      - src/req_arbiter.sv
      - src/addr_router.sv
      - src/clint_timer.sv
      - axi_master/axi_lane_adapter.sv
      - src/bus_unit_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/axi_mem_model.sv
      - tb/tb_bus_unit.sv

//--- tb/tb_bus_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_params.svh"

module tb_bus_unit;

  localparam int N_FETCH   = 12;
  localparam int N_STORE   = 24;
  localparam int N_TIE     = 6;
  localparam int N_TIMER   = 8;
  localparam int TXN_TOTAL = N_FETCH + 2 * N_STORE + 2 * N_TIE + N_TIMER;

  logic                clk;
  logic                rst;
  logic                fetch_valid_i;
  bus_pkg::addr_t      fetch_addr_i;
  logic                fetch_rvalid_o;
  bus_pkg::data_t      fetch_rdata_o;
  logic                ls_valid_i;
  logic                ls_write_i;
  bus_pkg::addr_t      ls_addr_i;
  bus_pkg::data_t      ls_wdata_i;
  bus_pkg::strb_t      ls_wstrb_i;
  logic                ls_rvalid_o;
  bus_pkg::data_t      ls_rdata_o;

  bus_pkg::axi_id_t    m_axi_arid, m_axi_awid, m_axi_rid, m_axi_bid;
  bus_pkg::addr_t      m_axi_araddr, m_axi_awaddr;
  bus_pkg::axi_len_t   m_axi_arlen, m_axi_awlen;
  bus_pkg::axi_size_t  m_axi_arsize, m_axi_awsize;
  bus_pkg::axi_burst_t m_axi_arburst, m_axi_awburst;
  bus_pkg::axi_resp_t  m_axi_rresp, m_axi_bresp;
  bus_pkg::axi_data_t  m_axi_rdata, m_axi_wdata;
  bus_pkg::axi_strb_t  m_axi_wstrb;
  logic                m_axi_arvalid, m_axi_arready, m_axi_rvalid, m_axi_rready, m_axi_rlast;
  logic                m_axi_awvalid, m_axi_awready, m_axi_wvalid, m_axi_wready, m_axi_wlast;
  logic                m_axi_bvalid, m_axi_bready;

  integer              seed;
  int                  err_cnt;
  int                  issued;
  logic [63:0]         mtime_ref;  // edges since reset released
  logic                tie_q;
  bus_pkg::data_t      exp_fetch;
  bus_pkg::data_t      exp_ls;
  logic [7:0]          shadow [bit [31:0]];
  bus_pkg::addr_t      a;
  bus_pkg::strb_t      strb;
  bus_pkg::data_t      d;
  logic [1:0]          kind;

  bus_unit_top u_dut (.*);

  axi_mem_model u_mem (
    .clk, .rst,
    .araddr_i  (m_axi_araddr),
    .arvalid_i (m_axi_arvalid),
    .arready_o (m_axi_arready),
    .rdata_o   (m_axi_rdata),
    .rvalid_o  (m_axi_rvalid),
    .rready_i  (m_axi_rready),
    .awaddr_i  (m_axi_awaddr),
    .awvalid_i (m_axi_awvalid),
    .awready_o (m_axi_awready),
    .wdata_i   (m_axi_wdata),
    .wstrb_i   (m_axi_wstrb),
    .wvalid_i  (m_axi_wvalid),
    .wready_o  (m_axi_wready),
    .bvalid_o  (m_axi_bvalid),
    .bready_i  (m_axi_bready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always_ff @(posedge clk) begin
    if (rst)
      mtime_ref <= '0;
    else
      mtime_ref <= mtime_ref + 64'd1;
  end

  function automatic bus_pkg::data_t fill_word(input bus_pkg::addr_t base);
    bus_pkg::addr_t loc;
    loc = {base[31:3], 3'b000};
    return base[2] ? (loc ^ 32'h5A5A_0000) : (loc ^ 32'hA5A5_0000);
  endfunction

  // memory pattern of the word overlaid with written bytes
  function automatic bus_pkg::data_t shadow_word(input bus_pkg::addr_t addr);
    bus_pkg::addr_t base;
    bus_pkg::data_t w;
    base = {addr[31:2], 2'b00};
    w = fill_word(base);
    for (int i = 0; i < 4; i++)
      if (shadow.exists(base + i))
        w[8*i +: 8] = shadow[base + i];
    return w;
  endfunction

  // axi size is log2 of the bytes moved
  function automatic bus_pkg::axi_size_t size_for_strb(input bus_pkg::strb_t s);
    int                 nbytes;
    bus_pkg::axi_size_t sz;
    nbytes = 0;
    for (int i = 0; i < 4; i++)
      nbytes += s[i];
    sz = '0;
    while ((1 << sz) < nbytes)
      sz++;
    return sz;
  endfunction

  function automatic bus_pkg::axi_strb_t lane_strb_for(input bus_pkg::addr_t addr,
                                                        input bus_pkg::strb_t s);
    bus_pkg::axi_strb_t r;
    r = '0;
    for (int i = 0; i < 4; i++)
      if (s[i])
        r[4 * addr[2] + addr[1:0] + i] = 1'b1;
    return r;
  endfunction

  function automatic bus_pkg::axi_data_t lane_data_for(input bus_pkg::addr_t addr,
                                                        input bus_pkg::data_t w);
    bus_pkg::data_t s;
    s = w << (8 * addr[1:0]);
    return {s, s};
  endfunction

  function automatic logic is_timer(input bus_pkg::addr_t addr);
    return addr == `BUS_MTIME_LO_ADDR || addr == `BUS_MTIME_HI_ADDR;
  endfunction

  function automatic bus_pkg::data_t timer_half(input logic [63:0] m, input bus_pkg::addr_t addr);
    return (addr == `BUS_MTIME_HI_ADDR) ? m[63:32] : m[31:0];
  endfunction

  function automatic bus_pkg::addr_t rand_word_addr();
    return 32'h8000_0000 | ($random(seed) & 32'h0000_00FC);  // small window so words get reused
  endfunction

  task automatic start_fetch(input bus_pkg::addr_t addr);
    fetch_valid_i <= 1'b1;
    fetch_addr_i  <= addr;
    exp_fetch     <= shadow_word(addr);
    issued++;
  endtask

  task automatic start_ls(input logic wr, input bus_pkg::addr_t addr,
                          input bus_pkg::strb_t s, input bus_pkg::data_t w);
    ls_valid_i <= 1'b1;
    ls_write_i <= wr;
    ls_addr_i  <= addr;
    ls_wstrb_i <= s;
    ls_wdata_i <= w;
    exp_ls     <= shadow_word(addr);
    issued++;
  endtask

  task automatic await_fetch();
    do @(posedge clk); while (!fetch_rvalid_o);
    fetch_valid_i <= 1'b0;
  endtask

  task automatic await_ls();
    do @(posedge clk); while (!ls_rvalid_o);
    ls_valid_i <= 1'b0;
  endtask

  task automatic fetch_word(input bus_pkg::addr_t addr);
    @(posedge clk);
    start_fetch(addr);
    await_fetch();
  endtask

  task automatic load_word(input bus_pkg::addr_t addr);
    @(posedge clk);
    start_ls(1'b0, addr, 4'hF, '0);
    await_ls();
  endtask

  task automatic store_bytes(input bus_pkg::addr_t addr, input bus_pkg::strb_t s,
                             input bus_pkg::data_t w);
    for (int i = 0; i < 4; i++)
      if (s[i])
        shadow[addr + i] = w[8*i +: 8];
    @(posedge clk);
    start_ls(1'b1, addr, s, w);
    await_ls();
  endtask

  // checks

  a_reset_quiet: assert property (@(posedge clk) $fell(rst) |->
      !(fetch_rvalid_o || ls_rvalid_o || m_axi_arvalid || m_axi_awvalid ||
        m_axi_wvalid || m_axi_rready || m_axi_bready))
    else begin
      err_cnt++;
      $display("control outputs not low after reset, time %0t", $time);
    end

  a_fetch_data: assert property (@(posedge clk) disable iff (rst)
      fetch_rvalid_o |-> fetch_rdata_o == exp_fetch)
    else begin
      err_cnt++;
      $display("ERR %0t fetch_rdata_o exp=%h got=%h", $time,
               $sampled(exp_fetch), $sampled(fetch_rdata_o));
    end

  a_load_data: assert property (@(posedge clk) disable iff (rst)
      ls_rvalid_o && !ls_write_i && !is_timer(ls_addr_i) |-> ls_rdata_o == exp_ls)
    else begin
      err_cnt++;
      $display("ERR %0t ls_rdata_o exp=%h got=%h", $time,
               $sampled(exp_ls), $sampled(ls_rdata_o));
    end

  a_aw_size: assert property (@(posedge clk) disable iff (rst)
      m_axi_awvalid |-> m_axi_awsize == size_for_strb(ls_wstrb_i))
    else begin
      err_cnt++;
      $display("ERR %0t m_axi_awsize exp=%h got=%h", $time,
               size_for_strb($sampled(ls_wstrb_i)), $sampled(m_axi_awsize));
    end

  a_w_strb: assert property (@(posedge clk) disable iff (rst)
      m_axi_wvalid |-> m_axi_wstrb == lane_strb_for(ls_addr_i, ls_wstrb_i))
    else begin
      err_cnt++;
      $display("ERR %0t m_axi_wstrb exp=%h got=%h", $time,
               lane_strb_for($sampled(ls_addr_i), $sampled(ls_wstrb_i)),
               $sampled(m_axi_wstrb));
    end

  a_w_data: assert property (@(posedge clk) disable iff (rst)
      m_axi_wvalid |-> m_axi_wdata == lane_data_for(ls_addr_i, ls_wdata_i))
    else begin
      err_cnt++;
      $display("ERR %0t m_axi_wdata exp=%h got=%h", $time,
               lane_data_for($sampled(ls_addr_i), $sampled(ls_wdata_i)),
               $sampled(m_axi_wdata));
    end

  // every read moves a full word
  a_ar_size: assert property (@(posedge clk) disable iff (rst)
      m_axi_arvalid |-> m_axi_arsize == size_for_strb(4'hF))
    else begin
      err_cnt++;
      $display("ERR %0t m_axi_arsize exp=%h got=%h", $time,
               size_for_strb(4'hF), $sampled(m_axi_arsize));
    end

  // one INCR beat with id zero
  a_ar_beat: assert property (@(posedge clk) disable iff (rst)
      m_axi_arvalid |-> m_axi_arlen == '0 && m_axi_arburst == 2'b01 && m_axi_arid == '0)
    else begin
      err_cnt++;
      $display("ERR %0t m_axi_arlen/arburst/arid exp=00/1/0 got=%h/%h/%h", $time,
               $sampled(m_axi_arlen), $sampled(m_axi_arburst), $sampled(m_axi_arid));
    end

  a_aw_beat: assert property (@(posedge clk) disable iff (rst)
      m_axi_awvalid |-> m_axi_awlen == '0 && m_axi_awburst == 2'b01 && m_axi_awid == '0)
    else begin
      err_cnt++;
      $display("ERR %0t m_axi_awlen/awburst/awid exp=00/1/0 got=%h/%h/%h", $time,
               $sampled(m_axi_awlen), $sampled(m_axi_awburst), $sampled(m_axi_awid));
    end

  a_w_last: assert property (@(posedge clk) disable iff (rst)
      m_axi_wvalid |-> m_axi_wlast)
    else begin
      err_cnt++;
      $display("ERR %0t m_axi_wlast exp=1 got=%b", $time, $sampled(m_axi_wlast));
    end

  // load/store has to finish first on same-cycle requests
  a_tie_order: assert property (@(posedge clk) disable iff (rst)
      tie_q && fetch_rvalid_o |-> !ls_valid_i)
    else begin
      err_cnt++;
      $display("fetch answered before the tied load/store, time %0t", $time);
    end

  a_timer_lat: assert property (@(posedge clk) disable iff (rst)
      $rose(ls_valid_i) && is_timer(ls_addr_i) |=> !ls_rvalid_o ##1 ls_rvalid_o)
    else begin
      err_cnt++;
      $display("timer response not 2 edges after capture, time %0t", $time);
    end

  a_timer_data: assert property (@(posedge clk) disable iff (rst)
      ls_rvalid_o && is_timer(ls_addr_i) |-> ls_rdata_o == timer_half(mtime_ref, ls_addr_i))
    else begin
      err_cnt++;
      $display("ERR %0t ls_rdata_o exp=%h got=%h", $time,
               timer_half($sampled(mtime_ref), $sampled(ls_addr_i)), $sampled(ls_rdata_o));
    end

  a_timer_no_axi: assert property (@(posedge clk) disable iff (rst)
      ls_valid_i && is_timer(ls_addr_i) |-> !(m_axi_arvalid || m_axi_awvalid || m_axi_wvalid))
    else begin
      err_cnt++;
      $display("AXI valid raised during a timer access, time %0t", $time);
    end

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
      m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr))
    else begin
      err_cnt++;
      $display("read address dropped or changed before arready, time %0t", $time);
    end

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
      m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
    else begin
      err_cnt++;
      $display("write address dropped or changed before awready, time %0t", $time);
    end

  a_w_hold: assert property (@(posedge clk) disable iff (rst)
      m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wdata))
    else begin
      err_cnt++;
      $display("write data dropped or changed before wready, time %0t", $time);
    end

  initial begin
    repeat (200 * TXN_TOTAL) @(posedge clk);
    $display("run stalled, %0d transactions issued, %0d errors", issued, err_cnt);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    seed          = 32'ha1ba014f;
    err_cnt       = 0;
    issued        = 0;
    tie_q         = 1'b0;
    exp_fetch     = '0;
    exp_ls        = '0;
    rst           = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    ls_valid_i    = 1'b0;
    ls_write_i    = 1'b0;
    ls_addr_i     = '0;
    ls_wdata_i    = '0;
    ls_wstrb_i    = '0;
    m_axi_rid     = '0;
    m_axi_rresp   = '0;
    m_axi_rlast   = 1'b1;
    m_axi_bid     = '0;
    m_axi_bresp   = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);

    for (int n = 0; n < N_FETCH; n++)
      fetch_word(rand_word_addr());

    // byte, half and word stores at legal offsets with a read back of each
    for (int n = 0; n < N_STORE; n++) begin
      a    = rand_word_addr();
      kind = $random(seed);
      d    = $random(seed);
      case (kind)
        2'd0: begin
          strb    = 4'h1;
          a[1:0]  = $random(seed);
        end
        2'd1: begin
          strb = 4'h3;
          a[1] = $random(seed);
        end
        default: strb = 4'hF;
      endcase
      store_bytes(a, strb, d);
      load_word({a[31:2], 2'b00});
    end

    for (int n = 0; n < N_TIE; n++) begin
      @(posedge clk);
      tie_q <= 1'b1;
      start_ls(1'b0, rand_word_addr(), 4'hF, '0);
      start_fetch(rand_word_addr());
      fork
        await_ls();
        await_fetch();
      join
      tie_q <= 1'b0;
    end

    for (int n = 0; n < N_TIMER; n++) begin
      repeat ($random(seed) & 3) @(posedge clk);
      load_word(n[0] ? `BUS_MTIME_HI_ADDR : `BUS_MTIME_LO_ADDR);
    end

    repeat (4) @(posedge clk);
    $display("transactions %0d, errors %0d", issued, err_cnt);
    if (err_cnt == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

// single outstanding AXI4 slave, random 0..3 cycle waits on every channel
module axi_mem_model (
  input  logic               clk,
  input  logic               rst,
  input  bus_pkg::addr_t     araddr_i,
  input  logic               arvalid_i,
  output logic               arready_o,
  output bus_pkg::axi_data_t rdata_o,
  output logic               rvalid_o,
  input  logic               rready_i,
  input  bus_pkg::addr_t     awaddr_i,
  input  logic               awvalid_i,
  output logic               awready_o,
  input  bus_pkg::axi_data_t wdata_i,
  input  bus_pkg::axi_strb_t wstrb_i,
  input  logic               wvalid_i,
  output logic               wready_o,
  output logic               bvalid_o,
  input  logic               bready_i
);

  bus_pkg::axi_data_t mem [bit [28:0]];  // sparse, pattern until first write
  integer             seed;
  logic [1:0]         ar_dly, r_dly, aw_dly, w_dly, b_dly;
  logic               r_pend, aw_got, w_got;
  bus_pkg::addr_t     rd_addr, wr_addr;
  bus_pkg::axi_data_t wr_data;
  bus_pkg::axi_strb_t wr_strb;
  bus_pkg::axi_data_t loc;

  function automatic bus_pkg::axi_data_t fill_loc(input bus_pkg::addr_t a);
    bus_pkg::addr_t base;
    base = {a[31:3], 3'b000};
    return {base ^ 32'h5A5A_0000, base ^ 32'hA5A5_0000};
  endfunction

  function automatic bus_pkg::axi_data_t read_loc(input bus_pkg::addr_t a);
    if (mem.exists(a[31:3]))
      return mem[a[31:3]];
    return fill_loc(a);
  endfunction

  initial seed = 32'ha1ba014f;

  always @(posedge clk) begin
    if (rst) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      rdata_o   <= '0;
      r_pend    <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      ar_dly    <= '0;
      r_dly     <= '0;
      aw_dly    <= '0;
      w_dly     <= '0;
      b_dly     <= '0;
    end else begin
      // read address
      if (arvalid_i && !arready_o && !r_pend) begin
        if (ar_dly == 0)
          arready_o <= 1'b1;
        else
          ar_dly <= ar_dly - 1'b1;
      end
      if (arvalid_i && arready_o) begin
        arready_o <= 1'b0;
        ar_dly    <= $random(seed);
        rd_addr   <= araddr_i;
        r_pend    <= 1'b1;
      end
      if (r_pend && !rvalid_o) begin
        if (r_dly == 0) begin
          rvalid_o <= 1'b1;
          rdata_o  <= read_loc(rd_addr);
        end else
          r_dly <= r_dly - 1'b1;
      end
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
        r_pend   <= 1'b0;
        r_dly    <= $random(seed);
      end

      // write address and data accepted independently
      if (awvalid_i && !awready_o && !aw_got) begin
        if (aw_dly == 0)
          awready_o <= 1'b1;
        else
          aw_dly <= aw_dly - 1'b1;
      end
      if (awvalid_i && awready_o) begin
        awready_o <= 1'b0;
        aw_dly    <= $random(seed);
        wr_addr   <= awaddr_i;
        aw_got    <= 1'b1;
      end
      if (wvalid_i && !wready_o && !w_got) begin
        if (w_dly == 0)
          wready_o <= 1'b1;
        else
          w_dly <= w_dly - 1'b1;
      end
      if (wvalid_i && wready_o) begin
        wready_o <= 1'b0;
        w_dly    <= $random(seed);
        wr_data  <= wdata_i;
        wr_strb  <= wstrb_i;
        w_got    <= 1'b1;
      end
      if (aw_got && w_got && !bvalid_o) begin
        if (b_dly == 0) begin
          loc = read_loc(wr_addr);
          for (int i = 0; i < 8; i++)
            if (wr_strb[i])
              loc[8*i +: 8] = wr_data[8*i +: 8];
          mem[wr_addr[31:3]] = loc;
          bvalid_o <= 1'b1;
          aw_got   <= 1'b0;
          w_got    <= 1'b0;
        end else
          b_dly <= b_dly - 1'b1;
      end
      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
        b_dly    <= $random(seed);
      end
    end
  end

endmodule

`default_nettype wire

//--- src/bus_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_unit_top (
  input  logic                clk,
  input  logic                rst,

  // fetch port
  input  logic                fetch_valid_i,
  input  bus_pkg::addr_t      fetch_addr_i,
  output logic                fetch_rvalid_o,
  output bus_pkg::data_t      fetch_rdata_o,

  // load/store port
  input  logic                ls_valid_i,
  input  logic                ls_write_i,
  input  bus_pkg::addr_t      ls_addr_i,
  input  bus_pkg::data_t      ls_wdata_i,
  input  bus_pkg::strb_t      ls_wstrb_i,
  output logic                ls_rvalid_o,
  output bus_pkg::data_t      ls_rdata_o,

  // axi4 master
  output bus_pkg::axi_id_t    m_axi_arid,
  output bus_pkg::addr_t      m_axi_araddr,
  output bus_pkg::axi_len_t   m_axi_arlen,
  output bus_pkg::axi_size_t  m_axi_arsize,
  output bus_pkg::axi_burst_t m_axi_arburst,
  output logic                m_axi_arvalid,
  input  logic                m_axi_arready,
  input  bus_pkg::axi_id_t    m_axi_rid,
  input  bus_pkg::axi_data_t  m_axi_rdata,
  input  bus_pkg::axi_resp_t  m_axi_rresp,
  input  logic                m_axi_rlast,
  input  logic                m_axi_rvalid,
  output logic                m_axi_rready,
  output bus_pkg::axi_id_t    m_axi_awid,
  output bus_pkg::addr_t      m_axi_awaddr,
  output bus_pkg::axi_len_t   m_axi_awlen,
  output bus_pkg::axi_size_t  m_axi_awsize,
  output bus_pkg::axi_burst_t m_axi_awburst,
  output logic                m_axi_awvalid,
  input  logic                m_axi_awready,
  output bus_pkg::axi_data_t  m_axi_wdata,
  output bus_pkg::axi_strb_t  m_axi_wstrb,
  output logic                m_axi_wlast,
  output logic                m_axi_wvalid,
  input  logic                m_axi_wready,
  input  bus_pkg::axi_id_t    m_axi_bid,
  input  bus_pkg::axi_resp_t  m_axi_bresp,
  input  logic                m_axi_bvalid,
  output logic                m_axi_bready
);

  mem_req_if cpu_req ();
  mem_req_if axi_req ();

  logic           clint_rd;
  logic           clint_hi;
  bus_pkg::data_t clint_data;

  req_arbiter u_arbiter (
    .clk, .rst,
    .fetch_valid_i, .fetch_addr_i, .fetch_rvalid_o, .fetch_rdata_o,
    .ls_valid_i, .ls_write_i, .ls_addr_i, .ls_wdata_i, .ls_wstrb_i,
    .ls_rvalid_o, .ls_rdata_o,
    .req (cpu_req.issuer)
  );

  addr_router u_router (
    .clk, .rst,
    .cpu          (cpu_req.target),
    .mem          (axi_req.issuer),
    .clint_rd_o   (clint_rd),
    .clint_hi_o   (clint_hi),
    .clint_data_i (clint_data)
  );

  clint_timer u_clint (
    .clk, .rst,
    .rd_i    (clint_rd),
    .hi_i    (clint_hi),
    .rdata_o (clint_data)
  );

  axi_lane_adapter u_axi (
    .clk, .rst,
    .req (axi_req.target),
    .m_axi_arid, .m_axi_araddr, .m_axi_arlen, .m_axi_arsize, .m_axi_arburst,
    .m_axi_arvalid, .m_axi_arready,
    .m_axi_rid, .m_axi_rdata, .m_axi_rresp, .m_axi_rlast, .m_axi_rvalid, .m_axi_rready,
    .m_axi_awid, .m_axi_awaddr, .m_axi_awlen, .m_axi_awsize, .m_axi_awburst,
    .m_axi_awvalid, .m_axi_awready,
    .m_axi_wdata, .m_axi_wstrb, .m_axi_wlast, .m_axi_wvalid, .m_axi_wready,
    .m_axi_bid, .m_axi_bresp, .m_axi_bvalid, .m_axi_bready
  );

endmodule

`default_nettype wire

//--- axi_master/axi_lane_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lane_adapter (
  input  logic                clk,
  input  logic                rst,

  mem_req_if.target           req,

  output bus_pkg::axi_id_t    m_axi_arid,
  output bus_pkg::addr_t      m_axi_araddr,
  output bus_pkg::axi_len_t   m_axi_arlen,
  output bus_pkg::axi_size_t  m_axi_arsize,
  output bus_pkg::axi_burst_t m_axi_arburst,
  output logic                m_axi_arvalid,
  input  logic                m_axi_arready,

  input  bus_pkg::axi_id_t    m_axi_rid,
  input  bus_pkg::axi_data_t  m_axi_rdata,
  input  bus_pkg::axi_resp_t  m_axi_rresp,
  input  logic                m_axi_rlast,
  input  logic                m_axi_rvalid,
  output logic                m_axi_rready,

  output bus_pkg::axi_id_t    m_axi_awid,
  output bus_pkg::addr_t      m_axi_awaddr,
  output bus_pkg::axi_len_t   m_axi_awlen,
  output bus_pkg::axi_size_t  m_axi_awsize,
  output bus_pkg::axi_burst_t m_axi_awburst,
  output logic                m_axi_awvalid,
  input  logic                m_axi_awready,

  output bus_pkg::axi_data_t  m_axi_wdata,
  output bus_pkg::axi_strb_t  m_axi_wstrb,
  output logic                m_axi_wlast,
  output logic                m_axi_wvalid,
  input  logic                m_axi_wready,

  input  bus_pkg::axi_id_t    m_axi_bid,
  input  bus_pkg::axi_resp_t  m_axi_bresp,
  input  logic                m_axi_bvalid,
  output logic                m_axi_bready
);

  function automatic bus_pkg::axi_size_t strb_to_size(input bus_pkg::strb_t strb);
    case (strb)
      4'h1:    return 3'd0;
      4'h3:    return 3'd1;
      default: return 3'd2;
    endcase
  endfunction

  bus_pkg::axi_state_e state_q;
  logic                aw_done_q;
  logic                w_done_q;
  logic                aw_ok;
  logic                w_ok;
  bus_pkg::strb_t      lane_strb;
  bus_pkg::data_t      lane_wdata;

  assign aw_ok = aw_done_q || (m_axi_awvalid && m_axi_awready);
  assign w_ok  = w_done_q || (m_axi_wvalid && m_axi_wready);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= bus_pkg::AX_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        bus_pkg::AX_IDLE: begin
          if (req.req_valid)
            state_q <= req.write ? bus_pkg::AX_WRITE : bus_pkg::AX_RADDR;
        end
        bus_pkg::AX_RADDR: if (m_axi_arready) state_q <= bus_pkg::AX_RDATA;
        bus_pkg::AX_RDATA: if (m_axi_rvalid) state_q <= bus_pkg::AX_IDLE;
        bus_pkg::AX_WRITE: begin
          aw_done_q <= aw_ok;
          w_done_q  <= w_ok;
          if (aw_ok && w_ok) begin  // both accepted, in any order
            state_q   <= bus_pkg::AX_WRESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end
        end
        bus_pkg::AX_WRESP: if (m_axi_bvalid) state_q <= bus_pkg::AX_IDLE;
        default: state_q <= bus_pkg::AX_IDLE;
      endcase
    end
  end

  // read address channel
  assign m_axi_arid    = '0;
  assign m_axi_araddr  = req.addr;
  assign m_axi_arlen   = '0;
  assign m_axi_arsize  = strb_to_size(req.wstrb);
  assign m_axi_arburst = bus_pkg::AXI_BURST_INCR;
  assign m_axi_arvalid = (state_q == bus_pkg::AX_RADDR);
  assign m_axi_rready  = (state_q == bus_pkg::AX_RDATA);

  // write side, shifted into the addressed bytes
  assign lane_strb  = req.wstrb << req.addr[1:0];
  assign lane_wdata = req.wdata << {req.addr[1:0], 3'b000};

  assign m_axi_awid    = '0;
  assign m_axi_awaddr  = req.addr;
  assign m_axi_awlen   = '0;
  assign m_axi_awsize  = strb_to_size(req.wstrb);
  assign m_axi_awburst = bus_pkg::AXI_BURST_INCR;
  assign m_axi_awvalid = (state_q == bus_pkg::AX_WRITE) && !aw_done_q;

  assign m_axi_wdata  = {lane_wdata, lane_wdata};
  assign m_axi_wstrb  = req.addr[2] ? {lane_strb, 4'h0} : {4'h0, lane_strb};
  assign m_axi_wlast  = 1'b1;  // single beat
  assign m_axi_wvalid = (state_q == bus_pkg::AX_WRITE) && !w_done_q;
  assign m_axi_bready = (state_q == bus_pkg::AX_WRESP);

  assign req.rsp_valid = ((state_q == bus_pkg::AX_RDATA) && m_axi_rvalid) ||
                         ((state_q == bus_pkg::AX_WRESP) && m_axi_bvalid);
  assign req.rdata     = req.addr[2] ? m_axi_rdata[63:32] : m_axi_rdata[31:0];

  a_r_okay: assert property (@(posedge clk) disable iff (rst)
    m_axi_rvalid && m_axi_rready |->
      m_axi_rresp == bus_pkg::AXI_RESP_OKAY && m_axi_rlast && m_axi_rid == '0);

  a_b_okay: assert property (@(posedge clk) disable iff (rst)
    m_axi_bvalid && m_axi_bready |->
      m_axi_bresp == bus_pkg::AXI_RESP_OKAY && m_axi_bid == '0);

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr));

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr));

  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wdata));

endmodule

`default_nettype wire

//--- src/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  logic           clk,
  input  logic           rst,
  input  logic           rd_i,
  input  logic           hi_i,
  output bus_pkg::data_t rdata_o
);

  logic [63:0] mtime_q;
  logic [63:0] mtime_next;

  assign mtime_next = mtime_q + 64'd1;

  // free running, one tick per clock
  always_ff @(posedge clk) begin
    if (rst)
      mtime_q <= '0;
    else
      mtime_q <= mtime_next;
  end

  // sample the value mtime takes on this edge,
  // so the data matches mtime during the response cycle
  always_ff @(posedge clk) begin
    if (rd_i) begin
      if (hi_i)
        rdata_o <= mtime_next[63:32];
      else
        rdata_o <= mtime_next[31:0];
    end
  end

endmodule

`default_nettype wire

//--- src/addr_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_params.svh"

module addr_router (
  input  logic           clk,
  input  logic           rst,

  mem_req_if.target      cpu,
  mem_req_if.issuer      mem,

  output logic           clint_rd_o,
  output logic           clint_hi_o,
  input  bus_pkg::data_t clint_data_i
);

  logic is_clint;
  logic clint_ack_q;  // timer answers one cycle after the request

  assign is_clint = (cpu.addr == `BUS_MTIME_LO_ADDR) || (cpu.addr == `BUS_MTIME_HI_ADDR);

  // timer writes are acked but ignored
  always_ff @(posedge clk) begin
    if (rst)
      clint_ack_q <= 1'b0;
    else
      clint_ack_q <= cpu.req_valid && is_clint && !clint_ack_q;
  end

  assign clint_rd_o = cpu.req_valid && is_clint && !cpu.write && !clint_ack_q;
  assign clint_hi_o = (cpu.addr == `BUS_MTIME_HI_ADDR);

  // everything else goes out on axi as is
  assign mem.req_valid = cpu.req_valid && !is_clint;
  assign mem.write     = cpu.write;
  assign mem.addr      = cpu.addr;
  assign mem.wdata     = cpu.wdata;
  assign mem.wstrb     = cpu.wstrb;

  assign cpu.rsp_valid = is_clint ? clint_ack_q : mem.rsp_valid;
  assign cpu.rdata     = is_clint ? clint_data_i : mem.rdata;

  // timer and axi side never answer together
  a_one_dest: assert property (@(posedge clk) disable iff (rst)
    !(clint_ack_q && mem.rsp_valid));

endmodule

`default_nettype wire

//--- src/req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module req_arbiter (
  input  logic           clk,
  input  logic           rst,

  input  logic           fetch_valid_i,
  input  bus_pkg::addr_t fetch_addr_i,
  output logic           fetch_rvalid_o,
  output bus_pkg::data_t fetch_rdata_o,

  input  logic           ls_valid_i,
  input  logic           ls_write_i,
  input  bus_pkg::addr_t ls_addr_i,
  input  bus_pkg::data_t ls_wdata_i,
  input  bus_pkg::strb_t ls_wstrb_i,
  output logic           ls_rvalid_o,
  output bus_pkg::data_t ls_rdata_o,

  mem_req_if.issuer      req
);

  bus_pkg::arb_state_e state_q;
  logic                owner_ls_q;  // load/store holds the bus
  logic                write_q;
  bus_pkg::addr_t      addr_q;
  bus_pkg::data_t      wdata_q;
  bus_pkg::strb_t      wstrb_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= bus_pkg::ARB_IDLE;
      owner_ls_q <= 1'b0;
    end else begin
      case (state_q)
        bus_pkg::ARB_IDLE: begin
          if (ls_valid_i || fetch_valid_i) begin
            state_q    <= bus_pkg::ARB_BUSY;
            owner_ls_q <= ls_valid_i;  // ls wins a tie
          end
        end
        bus_pkg::ARB_BUSY: begin
          if (req.rsp_valid)
            state_q <= bus_pkg::ARB_IDLE;
        end
        default: state_q <= bus_pkg::ARB_IDLE;
      endcase
    end
  end

  // latch the winner while idle
  always_ff @(posedge clk) begin
    if (state_q == bus_pkg::ARB_IDLE) begin
      if (ls_valid_i) begin
        addr_q  <= ls_addr_i;
        write_q <= ls_write_i;
        wdata_q <= ls_wdata_i;
        wstrb_q <= ls_wstrb_i;
      end else begin
        addr_q  <= fetch_addr_i;
        write_q <= 1'b0;  // fetch is always a full word read
        wdata_q <= '0;
        wstrb_q <= 4'hF;
      end
    end
  end

  assign req.req_valid = (state_q == bus_pkg::ARB_BUSY);
  assign req.write     = write_q;
  assign req.addr      = addr_q;
  assign req.wdata     = wdata_q;
  assign req.wstrb     = wstrb_q;

  assign fetch_rvalid_o = req.rsp_valid && (state_q == bus_pkg::ARB_BUSY) && !owner_ls_q;
  assign ls_rvalid_o    = req.rsp_valid && (state_q == bus_pkg::ARB_BUSY) && owner_ls_q;
  assign fetch_rdata_o  = req.rdata;
  assign ls_rdata_o     = req.rdata;

  // downstream may only answer a request that was issued
  a_no_rsp_idle: assert property (@(posedge clk) disable iff (rst)
    req.rsp_valid |-> state_q == bus_pkg::ARB_BUSY);

endmodule

`default_nettype wire

//--- common/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// one outstanding request, closed by a single rsp_valid pulse
interface mem_req_if;

  logic           req_valid;
  logic           write;
  bus_pkg::addr_t addr;
  bus_pkg::data_t wdata;
  bus_pkg::strb_t wstrb;
  logic           rsp_valid;
  bus_pkg::data_t rdata;

  modport issuer (
    output req_valid, write, addr, wdata, wstrb,
    input  rsp_valid, rdata
  );

  modport target (
    input  req_valid, write, addr, wdata, wstrb,
    output rsp_valid, rdata
  );

endinterface

`default_nettype wire

//--- common/bus_pkg.sv
`default_nettype none

`include "bus_params.svh"

package bus_pkg;

  typedef logic [`BUS_ADDR_W-1:0]     addr_t;
  typedef logic [`BUS_DATA_W-1:0]     data_t;
  typedef logic [`BUS_DATA_W/8-1:0]   strb_t;

  typedef logic [`BUS_AXI_DATA_W-1:0]   axi_data_t;
  typedef logic [`BUS_AXI_DATA_W/8-1:0] axi_strb_t;
  typedef logic [2:0]                   axi_size_t;
  typedef logic [7:0]                   axi_len_t;
  typedef logic [1:0]                   axi_burst_t;
  typedef logic [1:0]                   axi_resp_t;
  typedef logic [`BUS_AXI_ID_W-1:0]     axi_id_t;

  localparam axi_burst_t AXI_BURST_INCR = 2'b01;
  localparam axi_resp_t  AXI_RESP_OKAY  = 2'b00;

  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_e;

  typedef enum logic [2:0] {
    AX_IDLE,
    AX_RADDR,
    AX_RDATA,
    AX_WRITE,
    AX_WRESP
  } axi_state_e;

endpackage

`default_nettype wire

//--- common/bus_params.svh
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// core side widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// axi side, two core words per beat
`define BUS_AXI_DATA_W 64
`define BUS_AXI_ID_W   4

// core-local timer, low and high halves of mtime
`define BUS_MTIME_LO_ADDR 32'h0200_BFF8
`define BUS_MTIME_HI_ADDR 32'h0200_BFFC

`endif
